// ==== build.f ====
hw/itim_pkg.sv
hw/itim_bank.sv
hw/itim_decode.sv
hw/itim_ctrl.sv
hw/itim_wb_master.sv
hw/itim_top.sv
testbench/itim_wb_memory.sv
testbench/itim_tb.sv

// ==== testbench/itim_tb.sv ====
`timescale 1ns/1ns

module itim_tb
  import itim_pkg::*;
();

  localparam int num_requests = 400;
  localparam int max_wait = 3;
  localparam int clock_period = 40;
  localparam int timeout_ns =
    (8 + num_requests * (2 * (max_wait + 4) + itim_lines)) * clock_period;

  logic clock;
  logic reset;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  logic cyc;
  logic stb;
  logic we;
  logic [31:0] adr;
  logic [3:0] sel;
  logic [31:0] dat_r;
  logic ack;

  integer seed;
  int errors;
  int ready_count;
  int hits;
  int misses;
  int bypasses;
  int fences;
  logic [31:0] bus_log [$];
  logic prev_cyc;
  logic prev_ack;
  logic model_valid [itim_banks][itim_lines];
  logic [tag_bits-1:0] model_tag [itim_banks][itim_lines];

  itim_top dut_i (
    .clock (clock),
    .reset (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .cyc (cyc),
    .stb (stb),
    .we (we),
    .adr (adr),
    .sel (sel),
    .dat_r (dat_r),
    .ack (ack)
  );

  itim_wb_memory #(.max_wait(max_wait)) memory_i (
    .clock (clock),
    .cyc (cyc),
    .stb (stb),
    .adr (adr),
    .dat_r (dat_r),
    .ack (ack)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(timeout_ns);
    $display("Run timed out after %0d ns before all requests were answered", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return (a ^ 32'ha5a5_0000) + (a >> 2);
  endfunction

  function automatic logic cached(input logic [31:0] a);
    return model_valid[a[3:2]][a[9:4]] && (model_tag[a[3:2]][a[9:4]] == a[31:10]);
  endfunction

  // bus monitor sampled mid cycle.
  always @(negedge clock) begin
    if (reset) begin
      if (cyc !== stb) begin
        errors++;
        $display("Bus protocol error at %0t: cyc and stb differ", $time);
      end
      if (we !== 1'b0 || (cyc && sel !== 4'hf)) begin
        errors++;
        $display("Bus protocol error at %0t: write enable or byte select wrong", $time);
      end
      if (prev_cyc && !prev_ack && !cyc) begin
        errors++;
        $display("Bus protocol error at %0t: cycle ended without ack", $time);
      end
      if (cyc && ack) begin
        bus_log.push_back(adr);
      end
      if (fetch_rsp.ready) begin
        ready_count++;
      end
      prev_cyc = cyc;
      prev_ack = ack;
    end
  end

  task automatic run_fetch(input logic fence, input logic [31:0] addr);
    logic [31:0] addr1;
    logic [63:0] exp_rdata;
    int exp_reads;
    int latency;
    logic hit;
    addr1 = addr + 32'd4;
    exp_rdata = {expected_word(addr1), expected_word(addr)};
    exp_reads = 2;
    hit = 1'b0;
    if (fence) begin
      exp_rdata = '0;
      exp_reads = 0;
      fences++;
      for (int b = 0; b < itim_banks; b++) begin
        for (int l = 0; l < itim_lines; l++) begin
          model_valid[b][l] = 1'b0;
        end
      end
    end else if (addr >= itim_top_addr || addr1 >= itim_top_addr) begin
      bypasses++; // nothing is stored.
    end else if (cached(addr) && cached(addr1)) begin
      hit = 1'b1;
      exp_reads = 0;
      hits++;
    end else begin
      misses++;
      model_valid[addr[3:2]][addr[9:4]] = 1'b1;
      model_tag[addr[3:2]][addr[9:4]] = addr[31:10];
      model_valid[addr1[3:2]][addr1[9:4]] = 1'b1;
      model_tag[addr1[3:2]][addr1[9:4]] = addr1[31:10];
    end
    bus_log.delete();
    fetch_req.valid = 1'b1;
    fetch_req.fence = fence;
    fetch_req.addr = addr;
    latency = 0;
    do begin
      @(posedge clock);
      #2;
      fetch_req.valid = 1'b0;
      fetch_req.fence = 1'b0;
      latency++;
    end while (!fetch_rsp.ready);
    if (fetch_rsp.rdata !== exp_rdata) begin
      errors++;
      $display("Mismatch at %0t: rdata %h for addr %h, expected %h",
               $time, fetch_rsp.rdata, addr, exp_rdata);
    end
    if ((hit && latency != 1) || (fence && latency != itim_lines + 1)) begin
      errors++;
      $display("Mismatch at %0t: ready after %0d cycles for addr %h", $time, latency, addr);
    end
    if (bus_log.size() != exp_reads) begin
      errors++;
      $display("Mismatch at %0t: %0d bus reads for addr %h, expected %0d",
               $time, bus_log.size(), addr, exp_reads);
    end else if (exp_reads == 2 && (bus_log[0] !== addr || bus_log[1] !== addr1)) begin
      errors++;
      $display("Mismatch at %0t: bus read %h then %h, expected %h then %h",
               $time, bus_log[0], bus_log[1], addr, addr1);
    end
  endtask

  initial begin
    int pick;
    logic [31:0] addr;
    logic [31:0] last_addr;
    seed = 16;
    errors = 0;
    ready_count = 0;
    hits = 0;
    misses = 0;
    bypasses = 0;
    fences = 0;
    prev_cyc = 1'b0;
    prev_ack = 1'b0;
    reset = 1'b0;
    fetch_req = '0;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b1;
    @(posedge clock);
    #2;
    run_fetch(1'b1, 32'h0); // banks hold garbage until swept.
    last_addr = 32'h0;
    for (int n = 1; n < num_requests; n++) begin
      pick = $unsigned($random(seed)) % 100;
      if ($unsigned($random(seed)) % 4 == 0) begin
        @(posedge clock);
        #2;
      end
      if (pick < 5) begin
        run_fetch(1'b1, 32'h0);
      end else begin
        if (pick < 30) begin
          addr = last_addr;
        end else if (pick < 45) begin
          addr = 32'h0000_3ff8 + 4 * ($unsigned($random(seed)) % 8); // window edge.
        end else begin
          addr = (($unsigned($random(seed)) % 4) << 10) |
                 (($unsigned($random(seed)) % 8) << 4) |
                 (($unsigned($random(seed)) % 4) << 2);
        end
        run_fetch(1'b0, addr);
        last_addr = addr;
      end
    end
    @(posedge clock);
    #2;
    if (ready_count != num_requests) begin
      errors++;
      $display("Mismatch at %0t: %0d ready pulses for %0d requests",
               $time, ready_count, num_requests);
    end
    $display("requests %0d, hits %0d, misses %0d, bypasses %0d, fences %0d, errors %0d",
             num_requests, hits, misses, bypasses, fences, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== testbench/itim_wb_memory.sv ====
`timescale 1ns/1ns

module itim_wb_memory #(
  parameter int max_wait = 3
) (
  input logic clock,
  input logic cyc,
  input logic stb,
  input logic [31:0] adr,
  output logic [31:0] dat_r,
  output logic ack
);

  integer seed;
  int waits;
  logic active;

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return (a ^ 32'ha5a5_0000) + (a >> 2);
  endfunction

  initial begin
    seed = 16;
    waits = 0;
    active = 1'b0;
    ack = 1'b0;
    dat_r = '0;
  end

  always @(posedge clock) begin
    #2;
    if (ack) begin
      ack = 1'b0; // master took it on this edge.
      dat_r = '0;
    end else if (cyc && stb) begin
      if (!active) begin
        active = 1'b1;
        waits = $unsigned($random(seed)) % (max_wait + 1);
      end
      if (waits == 0) begin
        ack = 1'b1;
        dat_r = word_at(adr);
        active = 1'b0;
      end else begin
        waits = waits - 1;
      end
    end
  end

endmodule

// ==== hw/itim_top.sv ====
`timescale 1ns/1ns

module itim_top
  import itim_pkg::*;
(
  input logic clock,
  input logic reset,
  input fetch_req_t fetch_req,
  output fetch_rsp_t fetch_rsp,
  output logic cyc,
  output logic stb,
  output logic we,
  output logic [31:0] adr,
  output logic [3:0] sel,
  input logic [31:0] dat_r,
  input logic ack
);

  bank_in_t [itim_banks-1:0] bank_in;
  bank_in_t [itim_banks-1:0] bank_wr;
  bank_out_t [itim_banks-1:0] bank_out;
  logic [itim_banks-1:0][line_bits-1:0] raddr;
  dec_t dec;
  logic busy;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  for (genvar i = 0; i < itim_banks; i++) begin : g_bank
    // write side from control, read side from decode.
    assign bank_in[i].wen = bank_wr[i].wen;
    assign bank_in[i].waddr = bank_wr[i].waddr;
    assign bank_in[i].raddr = raddr[i];
    assign bank_in[i].wdata = bank_wr[i].wdata;

    itim_bank bank_i (
      .clock (clock),
      .bank_in (bank_in[i]),
      .bank_out (bank_out[i])
    );
  end

  itim_decode decode_i (
    .clock (clock),
    .reset (reset),
    .fetch_req (fetch_req),
    .busy (busy),
    .dec (dec),
    .raddr (raddr)
  );

  itim_ctrl ctrl_i (
    .clock (clock),
    .reset (reset),
    .dec (dec),
    .bank_out (bank_out),
    .bank_wr (bank_wr),
    .busy (busy),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .fetch_rsp (fetch_rsp)
  );

  itim_wb_master wb_master_i (
    .clock (clock),
    .reset (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .cyc (cyc),
    .stb (stb),
    .we (we),
    .adr (adr),
    .sel (sel),
    .dat_r (dat_r),
    .ack (ack)
  );

endmodule

// ==== hw/itim_wb_master.sv ====
`timescale 1ns/1ns

module itim_wb_master
  import itim_pkg::*;
(
  input logic clock,
  input logic reset,
  input bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  output logic cyc,
  output logic stb,
  output logic we,
  output logic [31:0] adr,
  output logic [3:0] sel,
  input logic [31:0] dat_r,
  input logic ack
);

  logic done_q;
  logic [31:0] rdata_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      cyc <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= cyc && ack;
      if (!cyc) begin
        cyc <= bus_req.valid;
      end else if (ack) begin
        cyc <= 1'b0; // cycle ends on the sampled ack.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!cyc && bus_req.valid) begin
      adr <= bus_req.addr;
    end
    if (cyc && ack) begin
      rdata_q <= dat_r;
    end
  end

  assign stb = cyc;
  assign we = 1'b0; // read only.
  assign sel = 4'hf;
  assign bus_rsp.done = done_q;
  assign bus_rsp.rdata = rdata_q;

endmodule

// ==== hw/itim_ctrl.sv ====
`timescale 1ns/1ns

module itim_ctrl
  import itim_pkg::*;
(
  input logic clock,
  input logic reset,
  input dec_t dec,
  input bank_out_t [itim_banks-1:0] bank_out,
  output bank_in_t [itim_banks-1:0] bank_wr,
  output logic busy,
  output bus_req_t bus_req,
  input bus_rsp_t bus_rsp,
  output fetch_rsp_t fetch_rsp
);

  logic [1:0] state;
  logic [1:0] state_next;
  logic second;
  logic [line_bits-1:0] count;
  logic [31:0] rdata_lo;

  bank_entry_t e0;
  bank_entry_t e1;
  bank_entry_t fill;
  fetch_addr_t word;
  logic outside;
  logic miss;

  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= itim_base_addr) && (addr < itim_top_addr);
  endfunction

  always_comb begin
    e0 = bank_out[dec.addr0.f.bank].rdata;
    e1 = bank_out[dec.addr1.f.bank].rdata;
    outside = !in_window(dec.addr0.raw) || !in_window(dec.addr1.raw);
    miss = !e0.valid || !e1.valid ||
           (e0.tag != dec.addr0.f.tag) || (e1.tag != dec.addr1.f.tag);

    word = second ? dec.addr1 : dec.addr0;
    fill.valid = 1'b1;
    fill.tag = word.f.tag;
    fill.data = bus_rsp.rdata;

    state_next = state;
    bus_req = '0;
    fetch_rsp = '0;
    bank_wr = '0;

    case (state)
      st_lookup: begin
        if (dec.valid) begin
          if (dec.fence) begin
            state_next = st_fence;
          end else if (outside || miss) begin
            state_next = outside ? st_bypass : st_miss;
            bus_req.valid = 1'b1;
            bus_req.addr = dec.addr0.raw;
          end else begin
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = {e1.data, e0.data};
          end
        end
      end
      st_miss, st_bypass: begin
        if (bus_rsp.done) begin
          if (state == st_miss) begin
            bank_wr[word.f.bank].wen = 1'b1; // refill one word per read.
            bank_wr[word.f.bank].waddr = word.f.line;
            bank_wr[word.f.bank].wdata = fill;
          end
          if (second) begin
            state_next = st_lookup;
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = {bus_rsp.rdata, rdata_lo};
          end else begin
            bus_req.valid = 1'b1;
            bus_req.addr = dec.addr1.raw;
          end
        end
      end
      default: begin
        // clear the same line in every bank.
        for (int i = 0; i < itim_banks; i++) begin
          bank_wr[i].wen = 1'b1;
          bank_wr[i].waddr = count;
        end
        if (count == line_bits'(itim_lines - 1)) begin
          state_next = st_lookup;
          fetch_rsp.ready = 1'b1;
        end
      end
    endcase

    // a new request may enter in the cycle of ready.
    busy = (state_next != st_lookup);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_lookup;
      second <= 1'b0;
      count <= '0;
    end else begin
      state <= state_next;
      if (bus_rsp.done) begin
        second <= !second;
      end
      if (state == st_fence) begin
        count <= count + 1'b1; // wraps to zero on exit.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus_rsp.done && !second) begin
      rdata_lo <= bus_rsp.rdata;
    end
  end

endmodule

// ==== hw/itim_decode.sv ====
`timescale 1ns/1ns

module itim_decode
  import itim_pkg::*;
(
  input logic clock,
  input logic reset,
  input fetch_req_t fetch_req,
  input logic busy,
  output dec_t dec,
  output logic [itim_banks-1:0][line_bits-1:0] raddr
);

  fetch_addr_t a0;
  fetch_addr_t a1;
  dec_t dec_next;

  always_comb begin
    a0.raw = fetch_req.addr;
    a1.raw = fetch_req.addr + 32'd4;

    // the two words always fall in different banks.
    raddr = '0;
    raddr[a0.f.bank] = a0.f.line;
    raddr[a1.f.bank] = a1.f.line;

    dec_next.valid = fetch_req.valid;
    dec_next.fence = fetch_req.fence;
    dec_next.addr0 = a0;
    dec_next.addr1 = a1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      dec.valid <= 1'b0;
    end else if (!busy) begin
      dec <= dec_next; // held while a refill runs.
    end
  end

endmodule

// ==== hw/itim_bank.sv ====
`timescale 1ns/1ns

module itim_bank
  import itim_pkg::*;
(
  input logic clock,
  input bank_in_t bank_in,
  output bank_out_t bank_out
);

  logic [entry_bits-1:0] mem [itim_lines];
  logic [line_bits-1:0] raddr_q;

  always_ff @(posedge clock) begin
    raddr_q <= bank_in.raddr;
    if (bank_in.wen) begin
      mem[bank_in.waddr] <= bank_in.wdata;
    end
  end

  // a write lands before the next read of the same line.
  assign bank_out.rdata = mem[raddr_q];

endmodule

// ==== hw/itim_pkg.sv ====
package itim_pkg;

  localparam int itim_banks = 4;
  localparam int itim_lines = 64;
  localparam int bank_bits = 2;
  localparam int line_bits = 6;
  localparam int tag_bits = 22;
  localparam int entry_bits = 55;

  localparam logic [31:0] itim_base_addr = 32'h0000_0000;
  localparam logic [31:0] itim_top_addr = 32'h0000_4000;

  localparam logic [1:0] st_lookup = 2'd0;
  localparam logic [1:0] st_miss = 2'd1;
  localparam logic [1:0] st_bypass = 2'd2;
  localparam logic [1:0] st_fence = 2'd3;

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_bits-1:0] tag;
      logic [line_bits-1:0] line;
      logic [bank_bits-1:0] bank;
      logic [1:0] offset;
    } f;
  } fetch_addr_t;

  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic ready;
    logic [63:0] rdata; // high word is addr+4.
  } fetch_rsp_t;

  typedef struct packed {
    logic wen;
    logic [line_bits-1:0] waddr;
    logic [line_bits-1:0] raddr;
    logic [entry_bits-1:0] wdata;
  } bank_in_t;

  typedef struct packed {
    logic [entry_bits-1:0] rdata;
  } bank_out_t;

  typedef struct packed {
    logic valid;
    logic [tag_bits-1:0] tag;
    logic [31:0] data;
  } bank_entry_t;

  typedef struct packed {
    logic valid;
    logic [31:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic done;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic valid;
    logic fence;
    fetch_addr_t addr0;
    fetch_addr_t addr1;
  } dec_t;

endpackage
